//--- Bender.yml
package:
  name: mm_subsys

export_include_dirs:
  - hdl

sources:
  # RTL, package first
  - include_dirs:
      - hdl
    files:
      - hdl/mm_pkg.sv
      - hdl/mm_cmd_decode.sv
      - hdl/mm_master.sv
      - hdl/mm_slave_mem.sv
      - hdl/mm_rsp_collect.sv
      - hdl/mm_subsys_top.sv

  # Testbench
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/mm_subsys_tb.sv

//--- dv/mm_subsys_tb.sv
//------------------------------------------------------------
// Table-driven testbench for the access subsystem with a
// reference memory and in-order response checks
//------------------------------------------------------------
`default_nettype none
`include "mm_consts.svh"

module mm_subsys_tb
    import mm_pkg::*;
();

    localparam int RDY_ON   = 0;    // rsp_ready high
    localparam int RDY_RAND = 1;    // rsp_ready random
    localparam int RDY_LOW  = 2;    // rsp_ready held low until the limit is shown
    localparam int HOLD_MIN = 16;   // Stall cycles at the limit before release

    typedef struct packed {
        mm_opcode_e                 op;
        logic [`MM_AWIDTH-1:0]      addr;
        logic [`MM_DWIDTH-1:0]      data;
        logic [`MM_DWIDTH-1:0]      exp;    // Read data, reads only
        logic [1:0]                 mode;
    } row_t;

    logic                       clk;
    logic                       reset;
    logic                       cmd_valid;
    logic                       cmd_ready;
    logic [`MM_CMD_WIDTH-1:0]   cmd_word;
    logic                       rsp_valid;
    logic                       rsp_ready;
    logic [`MM_AWIDTH-1:0]      rsp_addr;
    logic [`MM_DWIDTH-1:0]      rsp_data;
    logic                       err_illegal;
    logic                       err_unexpected;

    // Reference model and bookkeeping
    row_t                       rows [$];
    logic [`MM_DWIDTH-1:0]      ref_mem [2**`MM_AWIDTH];
    logic [`MM_AWIDTH+`MM_DWIDTH-1:0] exp_q [$];   // {addr, data} per read
    logic [`MM_AWIDTH+`MM_DWIDTH-1:0] exp_ent;
    logic [1:0]                 cur_mode;
    logic                       release_hold;
    logic [31:0]                rng_state;
    string                      test_name;
    int                         reads_acc;
    int                         rsp_cnt;
    int                         pending;
    int                         illegal_cnt;
    int                         rsvd_cnt;
    int                         read_rows;
    int                         cycles;
    int                         limit;

    mm_subsys_top mm_subsys_top_inst (
        .clk, .reset,
        .cmd_valid, .cmd_ready, .cmd_word,
        .rsp_valid, .rsp_ready, .rsp_addr, .rsp_data,
        .err_illegal, .err_unexpected
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //------------------------------------------------------------
    // Error reporting and helpers
    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        $display("TB FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic abort_run(string msg);
        $display("Error: %s", msg);
        $display("TB FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic void add_row(mm_opcode_e op, logic [7:0] addr, logic [15:0] data,
                                    logic [15:0] exp, logic [1:0] mode);
        rows.push_back('{op, addr, data, exp, mode});
        if (op == OP_READ) read_rows++;
    endfunction

    function automatic string name_of(row_t r);
        if (r.op == OP_NOP || r.op == OP_RSVD) return "nop_illegal";
        if (r.mode == RDY_RAND) return "ordering";
        if (r.mode == RDY_LOW) return "outstanding";
        return "write_read";
    endfunction

    task automatic check_idle();
        assert (rsp_valid === 1'b0) else report_mismatch("reset rsp_valid", 0, rsp_valid);
        assert (err_illegal === 1'b0) else report_mismatch("reset err_illegal", 0, err_illegal);
        assert (err_unexpected === 1'b0)
            else report_mismatch("reset err_unexpected", 0, err_unexpected);
    endtask

    // Reference memory and expected queue follow each accepted row
    task automatic apply_to_model(row_t r);
        case (r.op)
            OP_WRITE: ref_mem[r.addr] = r.data;
            OP_READ: begin
                assert (ref_mem[r.addr] === r.exp)
                    else report_mismatch({test_name, " table vs model"}, r.exp, ref_mem[r.addr]);
                exp_q.push_back({r.addr, r.exp});
            end
            OP_RSVD: rsvd_cnt++;    // Memory untouched
            default: ;
        endcase
    endtask

    //------------------------------------------------------------
    // Response port ready, mode taken from the row on offer
    always @(posedge clk) begin
        case (cur_mode)
            RDY_ON:   rsp_ready <= 1'b1;
            RDY_RAND: begin
                rng_state = xorshift32(rng_state);
                rsp_ready <= rng_state[7];
            end
            default:  rsp_ready <= release_hold;
        endcase
    end

    //------------------------------------------------------------
    // Monitor, samples settled values at the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: no progress within %0d cycles, %0d reads pending",
                         limit, exp_q.size());
                $display("TB FAILED");
                $fatal(1, "Run stopped on timeout");
            end
            pending = reads_acc - rsp_cnt;
            assert (!err_unexpected) else report_mismatch("protocol err_unexpected", 0, 1);
            // One more read can wait in the decode register
            assert (pending <= `MM_MAX_OUTSTANDING + 1)
                else report_mismatch("outstanding count", `MM_MAX_OUTSTANDING + 1, pending);
            if (pending == `MM_MAX_OUTSTANDING + 1) begin
                assert (!cmd_ready)
                    else abort_run("cmd_ready high with all read credits used");
            end
            if (cmd_valid && cmd_ready && cmd_word[`MM_CMD_WIDTH-1 -: 2] == OP_READ) begin
                reads_acc++;
            end
            if (rsp_valid && rsp_ready) begin
                assert (exp_q.size() != 0)
                    else abort_run("Response arrived with no read pending");
                exp_ent = exp_q.pop_front();
                assert (rsp_addr === exp_ent[`MM_DWIDTH +: `MM_AWIDTH])
                    else report_mismatch({test_name, " rsp_addr"},
                                         exp_ent[`MM_DWIDTH +: `MM_AWIDTH], rsp_addr);
                assert (rsp_data === exp_ent[`MM_DWIDTH-1:0])
                    else report_mismatch({test_name, " rsp_data"},
                                         exp_ent[`MM_DWIDTH-1:0], rsp_data);
                rsp_cnt++;
            end
            if (err_illegal) illegal_cnt++;
        end
    end

    //------------------------------------------------------------
    // Stimulus
    initial begin
        row_t row;
        int   stall;
        int   wait_cnt;

        reset        = 1'b1;
        cmd_valid    = 1'b0;
        cmd_word     = '0;
        rsp_ready    = 1'b0;
        cur_mode     = RDY_ON;
        release_hold = 1'b0;
        rng_state    = 32'd27;
        test_name    = "reset";
        {reads_acc, rsp_cnt, pending, illegal_cnt, rsvd_cnt, read_rows, cycles} = '0;

        // Writes, read back, overwrite
        add_row(OP_WRITE, 8'h00, 16'h1111, 16'h0000, RDY_ON);
        add_row(OP_WRITE, 8'h01, 16'h2222, 16'h0000, RDY_ON);
        add_row(OP_WRITE, 8'h10, 16'h3333, 16'h0000, RDY_ON);
        add_row(OP_WRITE, 8'hFF, 16'h4444, 16'h0000, RDY_ON);
        add_row(OP_READ,  8'h00, 16'h0000, 16'h1111, RDY_ON);
        add_row(OP_READ,  8'h10, 16'h0000, 16'h3333, RDY_ON);
        add_row(OP_WRITE, 8'h00, 16'h5555, 16'h0000, RDY_ON);
        add_row(OP_READ,  8'h00, 16'h0000, 16'h5555, RDY_ON);
        // NOP and RSVD leave memory alone
        add_row(OP_NOP,   8'h01, 16'h9999, 16'h0000, RDY_ON);
        add_row(OP_RSVD,  8'h10, 16'hDEAD, 16'h0000, RDY_ON);
        add_row(OP_READ,  8'h01, 16'h0000, 16'h2222, RDY_ON);
        add_row(OP_READ,  8'h10, 16'h0000, 16'h3333, RDY_ON);
        // Random back-pressure
        add_row(OP_READ,  8'hFF, 16'h0000, 16'h4444, RDY_RAND);
        add_row(OP_READ,  8'h00, 16'h0000, 16'h5555, RDY_RAND);
        add_row(OP_READ,  8'h01, 16'h0000, 16'h2222, RDY_RAND);
        add_row(OP_WRITE, 8'h01, 16'h6666, 16'h0000, RDY_RAND);
        add_row(OP_READ,  8'h01, 16'h0000, 16'h6666, RDY_RAND);
        add_row(OP_READ,  8'h10, 16'h0000, 16'h3333, RDY_RAND);
        add_row(OP_READ,  8'hFF, 16'h0000, 16'h4444, RDY_RAND);
        // Reads only, so the stall is on credits
        add_row(OP_READ,  8'h00, 16'h0000, 16'h5555, RDY_LOW);
        add_row(OP_READ,  8'h01, 16'h0000, 16'h6666, RDY_LOW);
        add_row(OP_READ,  8'h10, 16'h0000, 16'h3333, RDY_LOW);
        add_row(OP_READ,  8'hFF, 16'h0000, 16'h4444, RDY_LOW);
        add_row(OP_READ,  8'h00, 16'h0000, 16'h5555, RDY_LOW);
        add_row(OP_READ,  8'h01, 16'h0000, 16'h6666, RDY_LOW);
        add_row(OP_READ,  8'hFF, 16'h0000, 16'h4444, RDY_ON);
        add_row(OP_RSVD,  8'hFF, 16'h0BAD, 16'h0000, RDY_ON);
        add_row(OP_READ,  8'hFF, 16'h0000, 16'h4444, RDY_ON);
        limit = rows.size() * (`MM_LAT_MAX + 8) + 200;

        // Three edges under reset, outputs checked between edges
        @(posedge clk);
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        reset <= 1'b0;
        wait_cnt = 0;
        do begin
            @(posedge clk);
            check_idle();
            wait_cnt++;
            assert (wait_cnt <= 8) else abort_run("cmd_ready did not rise after reset");
        end while (!cmd_ready);

        foreach (rows[i]) begin
            row = rows[i];
            test_name = name_of(row);
            cmd_valid    <= 1'b1;
            cmd_word     <= {row.op, row.addr, row.data};
            cur_mode     <= row.mode;
            release_hold <= 1'b0;
            stall = 0;
            do begin
                @(posedge clk);
                stall++;
                if (row.mode == RDY_LOW && stall >= HOLD_MIN &&
                    pending == `MM_MAX_OUTSTANDING + 1) begin
                    release_hold <= 1'b1;   // Limit held long enough, drain
                end
            end while (!cmd_ready);
            apply_to_model(row);
        end
        cmd_valid <= 1'b0;
        cur_mode  <= RDY_ON;

        // Drain, then give a stray response time to show up
        while (exp_q.size() != 0) @(posedge clk);
        repeat (`MM_LAT_MAX + 4) @(posedge clk);
        test_name = "end";
        assert (rsp_cnt == read_rows)
            else report_mismatch("end response count", read_rows, rsp_cnt);
        assert (illegal_cnt == rsvd_cnt)
            else report_mismatch("nop_illegal err_illegal pulses", rsvd_cnt, illegal_cnt);
        assert (!err_unexpected) else report_mismatch("end err_unexpected", 0, 1);
        $display("TB PASSED");
        $finish;
    end

endmodule : mm_subsys_tb

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/mm_pkg.sv
hdl/mm_cmd_decode.sv
hdl/mm_master.sv
hdl/mm_slave_mem.sv
hdl/mm_rsp_collect.sv
hdl/mm_subsys_top.sv
dv/mm_subsys_tb.sv

//--- hdl/mm_cmd_decode.sv
//------------------------------------------------------------
// Command port, opcode decode and one-entry output register
//------------------------------------------------------------
`default_nettype none
`include "mm_consts.svh"

module mm_cmd_decode
    import mm_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    // Command port
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  logic [`MM_CMD_WIDTH-1:0]    cmd_word,

    // Decoded request towards the master
    output logic                        dec_valid,
    input  logic                        dec_ready,
    output logic                        dec_write,
    output logic [`MM_AWIDTH-1:0]       dec_addr,
    output logic [`MM_DWIDTH-1:0]       dec_data,

    output logic                        err_illegal     // One pulse per illegal code
);

    mm_opcode_e                 cmd_op;
    logic [`MM_AWIDTH-1:0]      cmd_addr;
    logic [`MM_DWIDTH-1:0]      cmd_data;
    logic                       cmd_fire;
    logic                       cmd_access;    // Read or write

    //------------------------------------------------------------
    // Command word split
    assign cmd_op   = mm_opcode_e'(cmd_word[`MM_CMD_WIDTH-1 -: `MM_OPWIDTH]);
    assign cmd_addr = cmd_word[`MM_DWIDTH +: `MM_AWIDTH];
    assign cmd_data = cmd_word[`MM_DWIDTH-1:0];

    // Register empty or draining this cycle
    assign cmd_ready  = ~dec_valid | dec_ready;
    assign cmd_fire   = cmd_valid & cmd_ready;
    assign cmd_access = (cmd_op == OP_READ) || (cmd_op == OP_WRITE);

    //------------------------------------------------------------
    // Output stage control
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec_valid   <= 1'b0;
            err_illegal <= 1'b0;
        end else begin
            err_illegal <= cmd_fire && (cmd_op == OP_RSVD);
            if (cmd_fire && cmd_access) begin
                dec_valid <= 1'b1;      // New entry, replaces a drained one
            end else if (dec_ready) begin
                dec_valid <= 1'b0;
            end
        end
    end

    // Payload, NOP and RSVD leave it untouched
    always_ff @(posedge clk) begin
        if (cmd_fire && cmd_access) begin
            dec_write <= (cmd_op == OP_WRITE);
            dec_addr  <= cmd_addr;
            dec_data  <= cmd_data;
        end
    end

endmodule : mm_cmd_decode

`default_nettype wire

//--- hdl/mm_consts.svh
//------------------------------------------------------------
// Widths, queue depths and latency limits of the
// memory-mapped access subsystem
//------------------------------------------------------------
`ifndef MM_CONSTS_SVH
`define MM_CONSTS_SVH

// Bus widths
`define MM_AWIDTH           8
`define MM_DWIDTH           16
`define MM_OPWIDTH          2
`define MM_CMD_WIDTH        (`MM_OPWIDTH + `MM_AWIDTH + `MM_DWIDTH)   // 26 bits

// Read credits and result queues, depth is a power of two
`define MM_MAX_OUTSTANDING  4
`define MM_OUT_PTR_W        2   // Queue index
`define MM_OUT_CNT_W        3   // Holds 0 to MM_MAX_OUTSTANDING

// Slave read pipe
`define MM_LAT_MAX          4
`define MM_LAT_PTR_W        2   // Pipe slot index
`define MM_LAT_CNT_W        3   // Pipe fill level
`define MM_LAT_DLY_W        2   // Per-slot countdown
`define MM_LFSR_W           16
`define MM_LFSR_SEED        16'hACE1

`endif

//--- hdl/mm_master.sv
//------------------------------------------------------------
// Bus master with request hold under busy and read credits
//------------------------------------------------------------
`default_nettype none
`include "mm_consts.svh"

module mm_master
    import mm_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    // Decoded requests
    input  logic                        dec_valid,
    output logic                        dec_ready,
    input  logic                        dec_write,
    input  logic [`MM_AWIDTH-1:0]       dec_addr,
    input  logic [`MM_DWIDTH-1:0]       dec_data,

    // Memory-mapped bus
    output logic [`MM_AWIDTH-1:0]       m_addr,
    output logic                        m_wreq,
    output logic [`MM_DWIDTH-1:0]       m_wdat,
    output logic                        m_rreq,
    input  logic                        m_busy,

    // Result stage bookkeeping
    output logic                        rd_issue,       // Read taken by the slave
    output logic [`MM_AWIDTH-1:0]       rd_issue_addr,
    input  logic                        rsp_pop         // One credit back
);

    mm_master_state_e           state;
    logic                       req_write;      // Held request is a write
    logic                       req_held;
    logic                       bus_take;
    logic                       dec_fire;
    logic                       credit_ok;
    logic [`MM_OUT_CNT_W-1:0]   out_cnt;        // Reads issued, not yet consumed

    //------------------------------------------------------------
    // Handshakes
    assign credit_ok = (out_cnt < `MM_MAX_OUTSTANDING);
    assign dec_ready = (state == ST_IDLE) && credit_ok;    // Writes wait too
    assign dec_fire  = dec_valid & dec_ready;

    assign req_held  = (state != ST_IDLE);
    assign m_wreq    = req_held & req_write;
    assign m_rreq    = req_held & ~req_write;
    assign bus_take  = req_held & ~m_busy;

    assign rd_issue      = m_rreq & ~m_busy;
    assign rd_issue_addr = m_addr;          // Stable while held

    //------------------------------------------------------------
    // Request FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= ST_IDLE;
            req_write <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (dec_fire) begin
                        state     <= ST_REQ;
                        req_write <= dec_write;
                    end
                end
                ST_REQ: begin
                    if (bus_take) begin
                        state <= ST_IDLE;
                    end else begin
                        state <= ST_STALL;  // Slave pushed back
                    end
                end
                ST_STALL: begin
                    if (bus_take) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Bus payload, captured with the request
    always_ff @(posedge clk) begin
        if (dec_fire) begin
            m_addr <= dec_addr;
            m_wdat <= dec_data;
        end
    end

    //------------------------------------------------------------
    // Read credits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_cnt <= '0;
        end else begin
            case ({rd_issue, rsp_pop})
                2'b10:   out_cnt <= out_cnt + 1'b1;
                2'b01:   out_cnt <= out_cnt - 1'b1;
                default: out_cnt <= out_cnt;    // Both or none
            endcase
        end
    end

endmodule : mm_master

`default_nettype wire

//--- hdl/mm_pkg.sv
//------------------------------------------------------------
// Opcode and FSM state types for the access subsystem
//------------------------------------------------------------
`default_nettype none

package mm_pkg;

    //------------------------------------------------------------
    // Command opcodes, top two bits of the command word
    typedef enum logic [1:0] {
        OP_NOP   = 2'b00,   // Consumed, no effect
        OP_WRITE = 2'b01,
        OP_READ  = 2'b10,
        OP_RSVD  = 2'b11    // Illegal code
    } mm_opcode_e;

    //------------------------------------------------------------
    // Bus master request FSM
    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,   // No request held
        ST_REQ   = 2'b01,   // Request on the bus
        ST_STALL = 2'b10    // Held under busy
    } mm_master_state_e;

    //------------------------------------------------------------
    // Slave acceptance state
    typedef enum logic {
        SL_READY = 1'b0,
        SL_BUSY  = 1'b1
    } mm_slave_state_e;

endpackage : mm_pkg

`default_nettype wire

//--- hdl/mm_rsp_collect.sv
//------------------------------------------------------------
// Read address queue and response buffer
//------------------------------------------------------------
`default_nettype none
`include "mm_consts.svh"

module mm_rsp_collect (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        rd_issue,
    input  logic [`MM_AWIDTH-1:0]       rd_issue_addr,
    input  logic                        m_rval,
    input  logic [`MM_DWIDTH-1:0]       m_rdat,

    // Response port
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [`MM_AWIDTH-1:0]       rsp_addr,
    output logic [`MM_DWIDTH-1:0]       rsp_data,

    output logic                        rsp_pop,        // Credit return
    output logic                        err_unexpected  // Sticky
);

    // Addresses of reads in flight
    logic [`MM_AWIDTH-1:0]      aq_mem [`MM_MAX_OUTSTANDING];
    logic [`MM_OUT_PTR_W-1:0]   aq_wr;
    logic [`MM_OUT_PTR_W-1:0]   aq_rd;
    logic [`MM_OUT_CNT_W-1:0]   aq_cnt;

    // Paired responses waiting for rsp_ready
    logic [`MM_AWIDTH-1:0]      rq_addr [`MM_MAX_OUTSTANDING];
    logic [`MM_DWIDTH-1:0]      rq_data [`MM_MAX_OUTSTANDING];
    logic [`MM_OUT_PTR_W-1:0]   rq_wr;
    logic [`MM_OUT_PTR_W-1:0]   rq_rd;
    logic [`MM_OUT_CNT_W-1:0]   rq_cnt;

    logic                       rsp_push;

    assign rsp_push  = m_rval && (aq_cnt != '0);
    assign rsp_valid = (rq_cnt != '0);
    assign rsp_addr  = rq_addr[rq_rd];
    assign rsp_data  = rq_data[rq_rd];
    assign rsp_pop   = rsp_valid & rsp_ready;

    //------------------------------------------------------------
    // Queue pointers and counts
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            aq_wr          <= '0;
            aq_rd          <= '0;
            aq_cnt         <= '0;
            rq_wr          <= '0;
            rq_rd          <= '0;
            rq_cnt         <= '0;
            err_unexpected <= 1'b0;
        end else begin
            if (rd_issue) aq_wr <= aq_wr + 1'b1;
            if (rsp_push) aq_rd <= aq_rd + 1'b1;
            aq_cnt <= aq_cnt + rd_issue - rsp_push;
            if (rsp_push) rq_wr <= rq_wr + 1'b1;
            if (rsp_pop)  rq_rd <= rq_rd + 1'b1;
            rq_cnt <= rq_cnt + rsp_push - rsp_pop;   // Credits bound it
            if (m_rval && (aq_cnt == '0)) begin
                err_unexpected <= 1'b1;              // Nothing pending
            end
        end
    end

    // Queue storage
    always_ff @(posedge clk) begin
        if (rd_issue) begin
            aq_mem[aq_wr] <= rd_issue_addr;
        end
        if (rsp_push) begin
            rq_addr[rq_wr] <= aq_mem[aq_rd];
            rq_data[rq_wr] <= m_rdat;
        end
    end

endmodule : mm_rsp_collect

`default_nettype wire

//--- hdl/mm_slave_mem.sv
//------------------------------------------------------------
// Memory slave with random busy and in-order 1 to 4 cycle
// read latency
//------------------------------------------------------------
`default_nettype none
`include "mm_consts.svh"

module mm_slave_mem
    import mm_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    input  logic [`MM_AWIDTH-1:0]       m_addr,
    input  logic                        m_wreq,
    input  logic [`MM_DWIDTH-1:0]       m_wdat,
    input  logic                        m_rreq,
    output logic                        m_busy,
    output logic [`MM_DWIDTH-1:0]       m_rdat,
    output logic                        m_rval      // One-cycle strobe
);

    logic [`MM_DWIDTH-1:0]      mem [2**`MM_AWIDTH];

    // Read pipe, circular and in order
    logic [`MM_DWIDTH-1:0]      pipe_data [`MM_LAT_MAX];
    logic [`MM_LAT_DLY_W-1:0]   pipe_dly [`MM_LAT_MAX];
    logic [`MM_LAT_MAX-1:0]     pipe_vld;
    logic [`MM_LAT_PTR_W-1:0]   wr_ptr;
    logic [`MM_LAT_PTR_W-1:0]   rd_ptr;
    logic [`MM_LAT_CNT_W-1:0]   fill;
    logic                       pipe_full;

    mm_slave_state_e            sl_state;
    logic [`MM_LFSR_W-1:0]      lfsr;
    logic                       lfsr_fb;
    logic                       wr_take;
    logic                       rd_take;

    //------------------------------------------------------------
    // Bus side
    assign pipe_full = (fill == `MM_LAT_MAX);
    assign m_busy    = (sl_state == SL_BUSY) | pipe_full;
    assign wr_take   = m_wreq & ~m_busy;
    assign rd_take   = m_rreq & ~m_busy;

    // Only the head may leave, so no reordering
    assign m_rval = pipe_vld[rd_ptr] && (pipe_dly[rd_ptr] == '0);
    assign m_rdat = pipe_data[rd_ptr];

    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // x^16+x^14+x^13+x^11

    //------------------------------------------------------------
    // LFSR, busy state and pipe control
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr     <= `MM_LFSR_SEED;
            sl_state <= SL_READY;
            pipe_vld <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            for (int i = 0; i < `MM_LAT_MAX; i++) begin
                pipe_dly[i] <= '0;
            end
        end else begin
            lfsr     <= {lfsr[14:0], lfsr_fb};
            sl_state <= (lfsr[3] & lfsr[8]) ? SL_BUSY : SL_READY;  // About 1 in 4
            for (int i = 0; i < `MM_LAT_MAX; i++) begin
                if (pipe_vld[i] && (pipe_dly[i] != '0)) begin
                    pipe_dly[i] <= pipe_dly[i] - 1'b1;
                end
            end
            if (m_rval) begin
                pipe_vld[rd_ptr] <= 1'b0;
                rd_ptr           <= rd_ptr + 1'b1;
            end
            if (rd_take) begin
                pipe_vld[wr_ptr] <= 1'b1;
                pipe_dly[wr_ptr] <= lfsr[5:4];  // Latency minus one
                wr_ptr           <= wr_ptr + 1'b1;
            end
            case ({rd_take, m_rval})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Array and read data, write lands at the accepting edge
    always_ff @(posedge clk) begin
        if (wr_take) begin
            mem[m_addr] <= m_wdat;
        end
        if (rd_take) begin
            pipe_data[wr_ptr] <= mem[m_addr];
        end
    end

endmodule : mm_slave_mem

`default_nettype wire

//--- hdl/mm_subsys_top.sv
//------------------------------------------------------------
// Access subsystem top, decode to master to slave to result
//------------------------------------------------------------
`default_nettype none
`include "mm_consts.svh"

module mm_subsys_top (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  logic [`MM_CMD_WIDTH-1:0]    cmd_word,

    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [`MM_AWIDTH-1:0]       rsp_addr,
    output logic [`MM_DWIDTH-1:0]       rsp_data,

    output logic                        err_illegal,
    output logic                        err_unexpected
);

    //------------------------------------------------------------
    // Internal nets
    logic                       dec_valid;
    logic                       dec_ready;
    logic                       dec_write;
    logic [`MM_AWIDTH-1:0]      dec_addr;
    logic [`MM_DWIDTH-1:0]      dec_data;

    logic [`MM_AWIDTH-1:0]      m_addr;
    logic                       m_wreq;
    logic [`MM_DWIDTH-1:0]      m_wdat;
    logic                       m_rreq;
    logic                       m_busy;
    logic [`MM_DWIDTH-1:0]      m_rdat;
    logic                       m_rval;

    logic                       rd_issue;
    logic [`MM_AWIDTH-1:0]      rd_issue_addr;
    logic                       rsp_pop;

    //------------------------------------------------------------
    mm_cmd_decode mm_cmd_decode_inst (
        .clk, .reset,
        .cmd_valid, .cmd_ready, .cmd_word,
        .dec_valid, .dec_ready, .dec_write, .dec_addr, .dec_data,
        .err_illegal
    );

    mm_master mm_master_inst (
        .clk, .reset,
        .dec_valid, .dec_ready, .dec_write, .dec_addr, .dec_data,
        .m_addr, .m_wreq, .m_wdat, .m_rreq, .m_busy,
        .rd_issue, .rd_issue_addr, .rsp_pop
    );

    mm_slave_mem mm_slave_mem_inst (
        .clk, .reset,
        .m_addr, .m_wreq, .m_wdat, .m_rreq,
        .m_busy, .m_rdat, .m_rval
    );

    mm_rsp_collect mm_rsp_collect_inst (
        .clk, .reset,
        .rd_issue, .rd_issue_addr, .m_rval, .m_rdat,
        .rsp_valid, .rsp_ready, .rsp_addr, .rsp_data,
        .rsp_pop, .err_unexpected
    );

endmodule : mm_subsys_top

`default_nettype wire
